//--- rtl/riscv_csr_pkg.sv
package riscv_csr_pkg;

    localparam int CSR_ADDR_W = 12;                       // CSR address field of the SYSTEM opcode
    localparam int XLEN       = 32;
    localparam int CAUSE_W    = 4;                        // Exception code field held in mcause

    // Machine trap setup
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISA     = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    // Machine trap handling
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL    = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP      = 12'h344;

    // Interrupt codes, mcause bit 31 set
    localparam logic [CAUSE_W-1:0] CAUSE_MSI = 4'd3;
    localparam logic [CAUSE_W-1:0] CAUSE_MTI = 4'd7;
    localparam logic [CAUSE_W-1:0] CAUSE_MEI = 4'd11;

    // Exception codes, mcause bit 31 clear
    localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL        = 4'd2;
    localparam logic [CAUSE_W-1:0] CAUSE_EBREAK         = 4'd3;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_MISALIGN  = 4'd4;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_MISALIGN = 4'd6;
    localparam logic [CAUSE_W-1:0] CAUSE_ECALL          = 4'd11;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;                 // Two bits, M-mode only so always 2'b11

    // Same positions in mie and mip
    localparam int IRQ_SW_BIT    = 3;
    localparam int IRQ_TIMER_BIT = 7;
    localparam int IRQ_EXT_BIT   = 11;

    // MXL = 1 (32 bit), extension I
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100;

    localparam logic [1:0]      MTVEC_MODE_DIRECT   = 2'b00;
    localparam logic [1:0]      MTVEC_MODE_VECTORED = 2'b01;  // Interrupts go to base + 4*code
    localparam logic [XLEN-1:0] MTVEC_RESET         = 32'h0000_0100;

endpackage

//--- rtl/csr_unit_pkg.sv
package csr_unit_pkg;

    // What the retiring instruction is, decoded by the core
    typedef enum logic [3:0] {
        KIND_PLAIN   = 4'd0,          // No CSR effect, can still be hit by an interrupt
        KIND_CSRRW   = 4'd1,
        KIND_CSRRS   = 4'd2,
        KIND_CSRRC   = 4'd3,
        KIND_LOAD    = 4'd4,
        KIND_STORE   = 4'd5,
        KIND_ECALL   = 4'd6,
        KIND_EBREAK  = 4'd7,
        KIND_MRET    = 4'd8,
        KIND_ILLEGAL = 4'd9
    } inst_kind_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } acc_size_t;

    typedef struct packed {
        inst_kind_t                                kind;
        acc_size_t                                 size;
        logic [riscv_csr_pkg::CSR_ADDR_W-1:0]      csr_addr;
        logic [riscv_csr_pkg::XLEN-1:0]            src;       // rs1 or zimm, chosen by the core
        logic [riscv_csr_pkg::XLEN-1:0]            pc;
        logic [riscv_csr_pkg::XLEN-1:0]            addr;      // Load/store effective address
    } csr_req_t;

    typedef struct packed {
        logic [riscv_csr_pkg::XLEN-1:0] rdata;    // Old CSR value
        logic                           trap;
        logic                           mret;
        logic [riscv_csr_pkg::XLEN-1:0] pc;       // Redirect target, zero when no redirect
    } csr_rsp_t;

    function automatic logic is_csr_kind(inst_kind_t kind);
        return (kind == KIND_CSRRW) || (kind == KIND_CSRRS) || (kind == KIND_CSRRC);
    endfunction

endpackage

//--- rtl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic [31:0]
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_valid,           // Upstream side
    output logic o_ready,
    input  T     i_data,
    output logic o_valid,           // Downstream side
    input  logic i_ready,
    output T     o_data
);

    logic valid_q;
    T     data_q;

    // Empty, or the held item leaves this edge
    assign o_ready = !valid_q || i_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            valid_q <= i_valid;     // Refill or drain
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid && o_ready)
            data_q <= i_data;       // Payload only moves on handshake
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule

//--- rtl/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
    input  csr_unit_pkg::inst_kind_t          i_kind,
    input  csr_unit_pkg::acc_size_t           i_size,
    input  logic [riscv_csr_pkg::XLEN-1:0]    i_addr,
    input  logic [riscv_csr_pkg::XLEN-1:0]    i_pc,
    input  logic                              i_mstatus_mie,
    input  logic [2:0]                        i_mie,          // {ext, timer, sw}
    input  logic [2:0]                        i_mip,          // Same order as i_mie
    input  logic [riscv_csr_pkg::XLEN-1:0]    i_mtvec,
    input  logic [riscv_csr_pkg::XLEN-1:0]    i_mepc,
    output logic                              o_take_trap,
    output logic                              o_take_mret,
    output logic                              o_cause_int,
    output logic [riscv_csr_pkg::CAUSE_W-1:0] o_cause_code,
    output logic [riscv_csr_pkg::XLEN-1:0]    o_tval,
    output logic [riscv_csr_pkg::XLEN-1:0]    o_redirect_pc
);
    import riscv_csr_pkg::*;
    import csr_unit_pkg::*;

    logic [2:0]      irq_pend;
    logic            misalign;
    logic            load_mis;
    logic            store_mis;
    logic [XLEN-1:0] vec_base;

    // Global enable, per-line enable and pending all needed
    assign irq_pend = i_mie & i_mip & {3{i_mstatus_mie}};

    always_comb begin
        case (i_size)
            SIZE_HALF: misalign = i_addr[0];
            SIZE_WORD: misalign = |i_addr[1:0];
            default:   misalign = 1'b0;             // Bytes are never misaligned
        endcase
    end

    assign load_mis  = (i_kind == KIND_LOAD) && misalign;
    assign store_mis = (i_kind == KIND_STORE) && misalign;

    // Interrupts first (ext, sw, timer), then synchronous causes
    always_comb begin
        o_take_trap  = 1'b1;
        o_cause_int  = 1'b0;
        o_cause_code = '0;
        if (irq_pend[2]) begin
            o_cause_int  = 1'b1;
            o_cause_code = CAUSE_MEI;
        end else if (irq_pend[0]) begin
            o_cause_int  = 1'b1;
            o_cause_code = CAUSE_MSI;
        end else if (irq_pend[1]) begin
            o_cause_int  = 1'b1;
            o_cause_code = CAUSE_MTI;
        end else if (i_kind == KIND_ILLEGAL) begin
            o_cause_code = CAUSE_ILLEGAL;
        end else if (i_kind == KIND_ECALL) begin
            o_cause_code = CAUSE_ECALL;
        end else if (i_kind == KIND_EBREAK) begin
            o_cause_code = CAUSE_EBREAK;
        end else if (load_mis) begin
            o_cause_code = CAUSE_LOAD_MISALIGN;
        end else if (store_mis) begin
            o_cause_code = CAUSE_STORE_MISALIGN;
        end else begin
            o_take_trap  = 1'b0;
        end
    end

    // A pending interrupt swallows the MRET
    assign o_take_mret = (i_kind == KIND_MRET) && !o_take_trap;

    // Faulting address for misaligned access, pc otherwise (regfile keeps only the former)
    assign o_tval = (load_mis || store_mis) ? i_addr : i_pc;

    assign vec_base = {i_mtvec[XLEN-1:2], 2'b00};

    always_comb begin
        if (o_take_trap && o_cause_int && (i_mtvec[1:0] == MTVEC_MODE_VECTORED)) begin
            o_redirect_pc = vec_base + {{(XLEN-CAUSE_W-2){1'b0}}, o_cause_code, 2'b00};
        end else if (o_take_trap) begin
            o_redirect_pc = vec_base;               // Direct mode and all exceptions
        end else if (o_take_mret) begin
            o_redirect_pc = i_mepc;
        end else begin
            o_redirect_pc = '0;
        end
    end

endmodule

//--- rtl/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_commit,       // Held request retires this edge
    input  csr_unit_pkg::inst_kind_t             i_kind,
    input  logic [riscv_csr_pkg::CSR_ADDR_W-1:0] i_csr_addr,
    input  logic [riscv_csr_pkg::XLEN-1:0]       i_src,
    input  logic [riscv_csr_pkg::XLEN-1:0]       i_pc,
    input  logic                                 i_irq_sw,
    input  logic                                 i_irq_timer,
    input  logic                                 i_irq_ext,
    input  logic                                 i_take_trap,
    input  logic                                 i_take_mret,
    input  logic                                 i_cause_int,
    input  logic [riscv_csr_pkg::CAUSE_W-1:0]    i_cause_code,
    input  logic [riscv_csr_pkg::XLEN-1:0]       i_tval,
    output logic [riscv_csr_pkg::XLEN-1:0]       o_rdata,
    output logic                                 o_mstatus_mie,
    output logic [2:0]                           o_mie,          // {ext, timer, sw}
    output logic [2:0]                           o_mip,
    output logic [riscv_csr_pkg::XLEN-1:0]       o_mtvec,
    output logic [riscv_csr_pkg::XLEN-1:0]       o_mepc
);
    import riscv_csr_pkg::*;
    import csr_unit_pkg::*;

    logic                 mstatus_mie;
    logic                 mstatus_mpie;
    logic [2:0]           mie_q;
    logic [2:0]           mip_q;
    logic [XLEN-3:0]      mtvec_base;
    logic [1:0]           mtvec_mode;
    logic [XLEN-1:0]      mscratch_q;
    logic [XLEN-1:0]      mepc_q;
    logic                 mcause_int;
    logic [CAUSE_W-1:0]   mcause_code;
    logic [XLEN-1:0]      mtval_q;
    logic [XLEN-1:0]      rdata;
    logic [XLEN-1:0]      wdata;
    logic                 csr_we;
    logic                 tval_we;

    // Spread {ext, timer, sw} over the mie/mip bit positions
    function automatic logic [XLEN-1:0] irq_word(logic [2:0] bits);
        logic [XLEN-1:0] w;
        w                = '0;
        w[IRQ_SW_BIT]    = bits[0];
        w[IRQ_TIMER_BIT] = bits[1];
        w[IRQ_EXT_BIT]   = bits[2];
        return w;
    endfunction

    always_comb begin
        rdata = '0;                                  // Unknown and ID CSRs read zero
        case (i_csr_addr)
            CSR_MSTATUS: begin
                rdata[MSTATUS_MIE_BIT]      = mstatus_mie;
                rdata[MSTATUS_MPIE_BIT]     = mstatus_mpie;
                rdata[MSTATUS_MPP_LSB +: 2] = 2'b11;  // Always came from M-mode
            end
            CSR_MISA:     rdata = MISA_VALUE;
            CSR_MIE:      rdata = irq_word(mie_q);
            CSR_MTVEC:    rdata = {mtvec_base, mtvec_mode};
            CSR_MSCRATCH: rdata = mscratch_q;
            CSR_MEPC:     rdata = mepc_q;
            CSR_MCAUSE:   rdata = {mcause_int, {(XLEN-CAUSE_W-1){1'b0}}, mcause_code};
            CSR_MTVAL:    rdata = mtval_q;
            CSR_MIP:      rdata = irq_word(mip_q);
            default:      rdata = '0;
        endcase
    end

    // Read-modify-write value
    always_comb begin
        case (i_kind)
            KIND_CSRRS: wdata = rdata | i_src;
            KIND_CSRRC: wdata = rdata & ~i_src;
            default:    wdata = i_src;               // CSRRW
        endcase
    end

    assign csr_we  = i_commit && is_csr_kind(i_kind);
    // Only misaligned causes carry a faulting address
    assign tval_we = !i_cause_int &&
                     ((i_cause_code == CAUSE_LOAD_MISALIGN) ||
                      (i_cause_code == CAUSE_STORE_MISALIGN));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_q        <= '0;
            mip_q        <= '0;
            mtvec_base   <= MTVEC_RESET[XLEN-1:2];
            mtvec_mode   <= MTVEC_RESET[1:0];
            mscratch_q   <= '0;
            mepc_q       <= '0;
            mcause_int   <= 1'b0;
            mcause_code  <= '0;
            mtval_q      <= '0;
        end else begin
            mip_q <= {i_irq_ext, i_irq_timer, i_irq_sw};    // Lines sampled every edge
            if (i_commit && i_take_trap) begin
                mstatus_mpie <= mstatus_mie;        // Stack MIE and mask
                mstatus_mie  <= 1'b0;
                mepc_q       <= i_pc;
                mcause_int   <= i_cause_int;
                mcause_code  <= i_cause_code;
                if (tval_we)
                    mtval_q <= i_tval;
            end else if (i_commit && i_take_mret) begin
                mstatus_mie  <= mstatus_mpie;       // Unstack
                mstatus_mpie <= 1'b1;
            end else if (csr_we) begin
                case (i_csr_addr)
                    CSR_MSTATUS: begin
                        mstatus_mie  <= wdata[MSTATUS_MIE_BIT];
                        mstatus_mpie <= wdata[MSTATUS_MPIE_BIT];
                    end
                    CSR_MIE: mie_q <= {wdata[IRQ_EXT_BIT], wdata[IRQ_TIMER_BIT],
                                       wdata[IRQ_SW_BIT]};
                    CSR_MTVEC: begin
                        mtvec_base <= wdata[XLEN-1:2];
                        // Reserved modes fall back to direct
                        mtvec_mode <= (wdata[1:0] == MTVEC_MODE_VECTORED) ?
                                      MTVEC_MODE_VECTORED : MTVEC_MODE_DIRECT;
                    end
                    CSR_MSCRATCH: mscratch_q <= wdata;
                    CSR_MEPC:     mepc_q     <= {wdata[XLEN-1:2], 2'b00};  // IALIGN 32
                    CSR_MCAUSE: begin
                        mcause_int  <= wdata[XLEN-1];
                        mcause_code <= wdata[CAUSE_W-1:0];
                    end
                    CSR_MTVAL:    mtval_q <= wdata;
                    default: ;                       // misa, mip and the rest ignore writes
                endcase
            end
        end
    end

    assign o_rdata       = rdata;
    assign o_mstatus_mie = mstatus_mie;
    assign o_mie         = mie_q;
    assign o_mip         = mip_q;
    assign o_mtvec       = {mtvec_base, mtvec_mode};
    assign o_mepc        = mepc_q;

endmodule

//--- rtl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    // Request from the core
    input  logic                                 i_req_valid,
    output logic                                 o_req_ready,
    input  csr_unit_pkg::inst_kind_t             i_req_kind,
    input  csr_unit_pkg::acc_size_t              i_req_size,
    input  logic [riscv_csr_pkg::CSR_ADDR_W-1:0] i_req_csr_addr,
    input  logic [riscv_csr_pkg::XLEN-1:0]       i_req_src,
    input  logic [riscv_csr_pkg::XLEN-1:0]       i_req_pc,
    input  logic [riscv_csr_pkg::XLEN-1:0]       i_req_addr,
    // Response
    output logic                                 o_rsp_valid,
    input  logic                                 i_rsp_ready,
    output logic [riscv_csr_pkg::XLEN-1:0]       o_rsp_rdata,
    output logic                                 o_rsp_trap,
    output logic                                 o_rsp_mret,
    output logic [riscv_csr_pkg::XLEN-1:0]       o_rsp_pc,
    // Level interrupt lines
    input  logic                                 i_irq_sw,
    input  logic                                 i_irq_timer,
    input  logic                                 i_irq_ext
);
    import riscv_csr_pkg::*;
    import csr_unit_pkg::*;

    csr_req_t           req_in;
    csr_req_t           req_q;
    logic               req_valid_q;
    csr_rsp_t           rsp_d;
    csr_rsp_t           rsp_q;
    logic               rsp_in_ready;
    logic               commit;
    logic               take_trap;
    logic               take_mret;
    logic               cause_int;
    logic [CAUSE_W-1:0] cause_code;
    logic [XLEN-1:0]    tval;
    logic [XLEN-1:0]    redirect_pc;
    logic [XLEN-1:0]    csr_rdata;
    logic               mstatus_mie;
    logic [2:0]         mie;
    logic [2:0]         mip;
    logic [XLEN-1:0]    mtvec;
    logic [XLEN-1:0]    mepc;

    assign req_in = '{kind: i_req_kind, size: i_req_size, csr_addr: i_req_csr_addr,
                      src: i_req_src, pc: i_req_pc, addr: i_req_addr};

    pipe_reg #(.T(csr_req_t)) u_req_stage (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_req_valid),
        .o_ready (o_req_ready),
        .i_data  (req_in),
        .o_valid (req_valid_q),
        .i_ready (rsp_in_ready),
        .o_data  (req_q)
    );

    // Retire once, on the edge the output stage takes the response
    assign commit = req_valid_q && rsp_in_ready;

    trap_ctrl u_trap_ctrl (
        .i_kind        (req_q.kind),
        .i_size        (req_q.size),
        .i_addr        (req_q.addr),
        .i_pc          (req_q.pc),
        .i_mstatus_mie (mstatus_mie),
        .i_mie         (mie),
        .i_mip         (mip),
        .i_mtvec       (mtvec),
        .i_mepc        (mepc),
        .o_take_trap   (take_trap),
        .o_take_mret   (take_mret),
        .o_cause_int   (cause_int),
        .o_cause_code  (cause_code),
        .o_tval        (tval),
        .o_redirect_pc (redirect_pc)
    );

    csr_regfile u_csr_regfile (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_commit      (commit),
        .i_kind        (req_q.kind),
        .i_csr_addr    (req_q.csr_addr),
        .i_src         (req_q.src),
        .i_pc          (req_q.pc),
        .i_irq_sw      (i_irq_sw),
        .i_irq_timer   (i_irq_timer),
        .i_irq_ext     (i_irq_ext),
        .i_take_trap   (take_trap),
        .i_take_mret   (take_mret),
        .i_cause_int   (cause_int),
        .i_cause_code  (cause_code),
        .i_tval        (tval),
        .o_rdata       (csr_rdata),
        .o_mstatus_mie (mstatus_mie),
        .o_mie         (mie),
        .o_mip         (mip),
        .o_mtvec       (mtvec),
        .o_mepc        (mepc)
    );

    // Old value only for a CSR access that actually retired
    assign rsp_d.rdata = (take_trap || !is_csr_kind(req_q.kind)) ? '0 : csr_rdata;
    assign rsp_d.trap  = take_trap;
    assign rsp_d.mret  = take_mret;
    assign rsp_d.pc    = redirect_pc;           // Already zero without a redirect

    pipe_reg #(.T(csr_rsp_t)) u_rsp_stage (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (req_valid_q),
        .o_ready (rsp_in_ready),
        .i_data  (rsp_d),
        .o_valid (o_rsp_valid),
        .i_ready (i_rsp_ready),
        .o_data  (rsp_q)
    );

    assign o_rsp_rdata = rsp_q.rdata;
    assign o_rsp_trap  = rsp_q.trap;
    assign o_rsp_mret  = rsp_q.mret;
    assign o_rsp_pc    = rsp_q.pc;

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;              // 8 ns period
    end

    // Reset held low for 4 rising edges, released just after the edge
    initial begin
        o_rst_n = 1'b0;
        repeat (4) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

//--- tests/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;
    import csr_unit_pkg::*;

    // One stimulus line with its request and expected response
    typedef struct packed {
        logic [31:0] id;
        logic [3:0]  kind;
        logic [1:0]  size;
        logic [11:0] csr_addr;
        logic [31:0] src;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [2:0]  irq;                        // {ext, timer, sw}
        logic [31:0] rdata;
        logic        trap;
        logic        mret;
        logic [31:0] rsp_pc;
    } stim_t;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    inst_kind_t  req_kind;
    acc_size_t   req_size;
    logic [11:0] req_csr_addr;
    logic [31:0] req_src;
    logic [31:0] req_pc;
    logic [31:0] req_addr;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_rdata;
    logic        rsp_trap;
    logic        rsp_mret;
    logic [31:0] rsp_pc;
    logic        irq_sw;
    logic        irq_timer;
    logic        irq_ext;

    stim_t       stim [$];
    bit          loaded;
    bit          load_ok;
    int          n_rsp;                          // Responses seen so far
    int          n_pass;
    int          n_fail;
    int          n_errors;                       // Failures outside any test
    int          test_errs;
    logic [31:0] cur_id;
    bit          have_test;
    integer      seed = 32'h553b13f4;

    tb_clk_gen u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    csr_unit u_csr_unit (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_req_valid    (req_valid),
        .o_req_ready    (req_ready),
        .i_req_kind     (req_kind),
        .i_req_size     (req_size),
        .i_req_csr_addr (req_csr_addr),
        .i_req_src      (req_src),
        .i_req_pc       (req_pc),
        .i_req_addr     (req_addr),
        .o_rsp_valid    (rsp_valid),
        .i_rsp_ready    (rsp_ready),
        .o_rsp_rdata    (rsp_rdata),
        .o_rsp_trap     (rsp_trap),
        .o_rsp_mret     (rsp_mret),
        .o_rsp_pc       (rsp_pc),
        .i_irq_sw       (irq_sw),
        .i_irq_timer    (irq_timer),
        .i_irq_ext      (irq_ext)
    );

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] t_id, t_kind, t_size, t_csr, t_src, t_pc, t_addr;
        logic [31:0] t_sw, t_tim, t_ext, t_rdata, t_trap, t_mret, t_rpc;
        stim_t       s;
        ok = 1'b1;
        fd = $fopen("tests/csr_unit_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/csr_unit_stimulus.txt");
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != 8'h23) begin    // Skip blanks and '#'
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  t_id, t_kind, t_size, t_csr, t_src, t_pc, t_addr,
                                  t_sw, t_tim, t_ext, t_rdata, t_trap, t_mret, t_rpc);
                    if (cnt != 14) begin
                        $display("Malformed stimulus line: %s", line);
                        ok = 1'b0;
                    end else begin
                        s.id       = t_id;
                        s.kind     = t_kind[3:0];
                        s.size     = t_size[1:0];
                        s.csr_addr = t_csr[11:0];
                        s.src      = t_src;
                        s.pc       = t_pc;
                        s.addr     = t_addr;
                        s.irq      = {t_ext[0], t_tim[0], t_sw[0]};
                        s.rdata    = t_rdata;
                        s.trap     = t_trap[0];
                        s.mret     = t_mret[0];
                        s.rsp_pc   = t_rpc;
                        stim.push_back(s);
                    end
                end
            end
            $fclose(fd);
            if (stim.size() == 0) begin
                $display("Stimulus file holds no requests");
                ok = 1'b0;
            end
        end
    endtask

    // Called at rising edge + 1 ns and returns at the same point after the transfer
    task automatic send_req(input stim_t s);
        req_kind     = inst_kind_t'(s.kind);
        req_size     = acc_size_t'(s.size);
        req_csr_addr = s.csr_addr;
        req_src      = s.src;
        req_pc       = s.pc;
        req_addr     = s.addr;
        req_valid    = 1'b1;
        @(negedge clk);
        while (!req_ready) @(negedge clk);       // Fields held while stalled
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // Requests with unchanged interrupt levels go back to back
    task automatic run_requests();
        int         i;
        logic [2:0] irq_now;
        irq_now = 3'b000;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        for (i = 0; i < stim.size(); i++) begin
            if (stim[i].irq != irq_now) begin
                wait (n_rsp == i);               // Drain so older requests see old levels
                @(posedge clk);
                #1;
                irq_now = stim[i].irq;
                {irq_ext, irq_timer, irq_sw} = stim[i].irq;
                repeat (3) @(posedge clk);       // mip picks the lines up a cycle late
                #1;
            end
            send_req(stim[i]);
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h (test %0d, request %0d)",
                     $time, name, got, exp, cur_id, n_rsp);
            test_errs++;
        end
    endtask

    task automatic close_test();
        if (test_errs == 0) begin
            $display("test %0d passed", cur_id);
            n_pass++;
        end else begin
            $display("test %0d failed with %0d mismatches", cur_id, test_errs);
            n_fail++;
        end
        test_errs = 0;
    endtask

    task automatic check_response();
        stim_t s;
        assert (n_rsp < stim.size()) else begin
            $display("Response at %0t ns arrived with no request outstanding", $time);
            n_errors++;
        end
        if (n_rsp < stim.size()) begin
            s = stim[n_rsp];                     // Responses come back in request order
            if (have_test && s.id != cur_id)
                close_test();
            cur_id    = s.id;
            have_test = 1'b1;
            compare_field("rdata", rsp_rdata, s.rdata);
            compare_field("trap", {31'd0, rsp_trap}, {31'd0, s.trap});
            compare_field("mret", {31'd0, rsp_mret}, {31'd0, s.mret});
            compare_field("pc", rsp_pc, s.rsp_pc);
            if (n_rsp + 1 == stim.size())
                close_test();
            n_rsp++;                             // Counted last so the end waits for the report
        end
    endtask

    // Random back-pressure with about three accepts in four
    initial begin
        rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rsp_ready = ($random(seed) & 3) != 0;
        end
    end

    // Inputs settle 1 ns after the edge, so the negedge sees what the next edge takes
    initial begin
        n_rsp     = 0;
        n_pass    = 0;
        n_fail    = 0;
        n_errors  = 0;
        test_errs = 0;
        have_test = 1'b0;
        cur_id    = '0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        assert (!rsp_valid && req_ready) else begin
            $display("Handshake outputs wrong after reset at %0t ns", $time);
            n_errors++;
        end
        forever begin
            @(negedge clk);
            if (rsp_valid && rsp_ready)
                check_response();
        end
    end

    initial begin
        wait (loaded);
        repeat (stim.size() * 40) @(posedge clk);
        $display("Watchdog expired after %0d cycles, responses stopped arriving",
                 stim.size() * 40);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        req_valid    = 1'b0;
        req_kind     = KIND_PLAIN;
        req_size     = SIZE_BYTE;
        req_csr_addr = '0;
        req_src      = '0;
        req_pc       = '0;
        req_addr     = '0;
        irq_sw       = 1'b0;
        irq_timer    = 1'b0;
        irq_ext      = 1'b0;
        loaded       = 1'b0;
        load_stimulus(load_ok);
        if (!load_ok) begin
            $display("Stimulus file could not be used");
            $display("TEST FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            run_requests();
            wait (n_rsp == stim.size());
            $display("%0d tests passed, %0d tests failed, %0d other errors",
                     n_pass, n_fail, n_errors);
            if (n_fail == 0 && n_errors == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

//--- tests/csr_unit_stimulus.txt
# id kind size csr src pc addr irq_sw irq_timer irq_ext | exp_rdata exp_trap exp_mret exp_pc
# All hex; kind 0 plain 1 rw 2 rs 3 rc 4 load 5 store 6 ecall 7 ebreak 8 mret 9 illegal
1 1 0 340 a5a50f0f 00001000 00000000 0 0 0 00000000 0 0 00000000
1 2 0 340 0000f0f0 00001004 00000000 0 0 0 a5a50f0f 0 0 00000000
1 3 0 340 a0000003 00001008 00000000 0 0 0 a5a5ffff 0 0 00000000
1 2 0 340 00000000 0000100c 00000000 0 0 0 05a5fffc 0 0 00000000
2 6 0 000 00000000 00002000 00000000 0 0 0 00000000 1 0 00000100
2 2 0 342 00000000 00002004 00000000 0 0 0 0000000b 0 0 00000000
2 7 0 000 00000000 00002010 00000000 0 0 0 00000000 1 0 00000100
2 2 0 341 00000000 00002014 00000000 0 0 0 00002010 0 0 00000000
2 2 0 343 00000000 00002018 00000000 0 0 0 00000000 0 0 00000000
2 9 0 000 00000000 00002020 00000000 0 0 0 00000000 1 0 00000100
2 2 0 342 00000000 00002024 00000000 0 0 0 00000002 0 0 00000000
2 4 1 000 00000000 00002030 00003001 0 0 0 00000000 1 0 00000100
2 2 0 343 00000000 00002034 00000000 0 0 0 00003001 0 0 00000000
2 5 2 000 00000000 00002040 00004002 0 0 0 00000000 1 0 00000100
2 2 0 342 00000000 00002044 00000000 0 0 0 00000006 0 0 00000000
3 1 0 305 00000201 00003000 00000000 0 0 0 00000100 0 0 00000000
3 1 0 304 00000888 00003004 00000000 0 0 0 00000000 0 0 00000000
3 2 0 300 00000008 00003008 00000000 0 0 0 00001800 0 0 00000000
3 0 0 000 00000000 00003100 00000000 1 1 1 00000000 1 0 0000022c
3 2 0 300 00000000 00003104 00000000 1 1 1 00001880 0 0 00000000
3 2 0 342 00000000 00003108 00000000 1 1 1 8000000b 0 0 00000000
3 2 0 344 00000000 0000310c 00000000 1 1 1 00000888 0 0 00000000
4 8 0 000 00000000 00004000 00000000 0 0 0 00000000 0 1 00003100
4 3 0 304 00000800 00004004 00000000 0 0 0 00000888 0 0 00000000
4 0 0 000 00000000 00004010 00000000 0 0 1 00000000 0 0 00000000
4 3 0 300 00000008 00004014 00000000 0 0 1 00001888 0 0 00000000
4 0 0 000 00000000 00004020 00000000 0 1 1 00000000 0 0 00000000
4 2 0 300 00000008 00004030 00000000 1 1 1 00001880 0 0 00000000
4 0 0 000 00000000 00004034 00000000 1 1 1 00000000 1 0 0000020c
4 8 0 000 00000000 00004040 00000000 1 1 1 00000000 0 1 00004034
4 0 0 000 00000000 00004044 00000000 1 1 1 00000000 1 0 0000020c
5 1 0 340 00000011 00005000 00000000 0 0 0 05a5fffc 0 0 00000000
5 1 0 340 00000022 00005004 00000000 0 0 0 00000011 0 0 00000000
5 2 0 340 00000100 00005008 00000000 0 0 0 00000022 0 0 00000000
5 1 0 341 00005003 0000500c 00000000 0 0 0 00004044 0 0 00000000
5 2 0 341 00000000 00005010 00000000 0 0 0 00005000 0 0 00000000
5 2 0 340 00000000 00005014 00000000 0 0 0 00000122 0 0 00000000
5 2 0 300 00000000 00005018 00000000 0 0 0 00001880 0 0 00000000

//--- Makefile
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f csr_unit.f --top-module csr_unit_tb \
		-Mdir $(OBJ_DIR) -o csr_unit_sim

run: compile
	./$(OBJ_DIR)/csr_unit_sim | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- csr_unit.f
rtl/riscv_csr_pkg.sv
rtl/csr_unit_pkg.sv
rtl/pipe_reg.sv
rtl/trap_ctrl.sv
rtl/csr_regfile.sv
rtl/csr_unit.sv
tests/tb_clk_gen.sv
tests/csr_unit_tb.sv
